//--- rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_W   32
`define REG_AW   5
`define REG_NUM  32
`define IMM_W    16
`define JIDX_W   26
`define LINK_REG 31

// instruction word fields
`define OP_F     31:26
`define RS_F     25:21
`define RT_F     20:16
`define RD_F     15:11
`define SA_F     10:6
`define FN_F     5:0
`define IMM_F    15:0
`define JIDX_F   25:0

`endif

//--- rtl/decode_pkg.sv
package decode_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC2_REG, SRC2_SIMM, SRC2_UIMM, SRC2_8
    } src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ,
        BR_JUMP, BR_JUMP_REG
    } br_kind_e;

endpackage

//--- rtl/inst_decoder.sv
`include "cpu_settings.svh"

module inst_decoder (
    input  logic [`DATA_W-1:0]     inst,
    output logic [`REG_AW-1:0]     rs,
    output logic [`REG_AW-1:0]     rt,
    output decode_pkg::alu_op_e    alu_op,
    output logic                   src1_is_sa,
    output logic                   src1_is_pc,
    output decode_pkg::src2_sel_e  src2_sel,
    output logic                   gr_we,
    output logic                   mem_we,
    output logic                   mem_re,
    output logic [`REG_AW-1:0]     dest,
    output logic [`IMM_W-1:0]      imm,
    output logic [`JIDX_W-1:0]     jidx,
    output decode_pkg::br_kind_e   br_kind
);
    decode_pkg::opcode_e  op;
    decode_pkg::funct_e   fn;
    logic [`REG_AW-1:0]   rd;
    logic                 rs_zero;
    logic                 rt_zero;
    logic                 rd_zero;
    logic                 sa_zero;

    assign op   = decode_pkg::opcode_e'(inst[`OP_F]);
    assign fn   = decode_pkg::funct_e'(inst[`FN_F]);
    assign rs   = inst[`RS_F];
    assign rt   = inst[`RT_F];
    assign rd   = inst[`RD_F];
    assign imm  = inst[`IMM_F];
    assign jidx = inst[`JIDX_F];

    // fields that must be zero for a legal encoding
    assign rs_zero = (rs == '0);
    assign rt_zero = (rt == '0);
    assign rd_zero = (rd == '0);
    assign sa_zero = (inst[`SA_F] == '0);

    always_comb begin
        alu_op     = decode_pkg::ALU_ADD;
        src1_is_sa = 1'b0;
        src1_is_pc = 1'b0;
        src2_sel   = decode_pkg::SRC2_REG;
        gr_we      = 1'b0;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        dest       = rd;
        br_kind    = decode_pkg::BR_NONE;
        case (op)
            decode_pkg::OP_SPECIAL: begin
                case (fn)
                    decode_pkg::FN_SUBU: alu_op = decode_pkg::ALU_SUB;
                    decode_pkg::FN_SLT:  alu_op = decode_pkg::ALU_SLT;
                    decode_pkg::FN_SLTU: alu_op = decode_pkg::ALU_SLTU;
                    decode_pkg::FN_AND:  alu_op = decode_pkg::ALU_AND;
                    decode_pkg::FN_OR:   alu_op = decode_pkg::ALU_OR;
                    decode_pkg::FN_XOR:  alu_op = decode_pkg::ALU_XOR;
                    decode_pkg::FN_NOR:  alu_op = decode_pkg::ALU_NOR;
                    decode_pkg::FN_SLL:  alu_op = decode_pkg::ALU_SLL;
                    decode_pkg::FN_SRL:  alu_op = decode_pkg::ALU_SRL;
                    decode_pkg::FN_SRA:  alu_op = decode_pkg::ALU_SRA;
                    default:             alu_op = decode_pkg::ALU_ADD;
                endcase
                case (fn)
                    decode_pkg::FN_ADDU, decode_pkg::FN_SUBU, decode_pkg::FN_SLT,
                    decode_pkg::FN_SLTU, decode_pkg::FN_AND, decode_pkg::FN_OR,
                    decode_pkg::FN_XOR, decode_pkg::FN_NOR: begin
                        gr_we = sa_zero;
                    end
                    decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA: begin
                        gr_we      = rs_zero;
                        src1_is_sa = rs_zero;
                    end
                    decode_pkg::FN_JR: begin
                        if (rt_zero && rd_zero && sa_zero) begin
                            br_kind = decode_pkg::BR_JUMP_REG;
                        end
                    end
                    decode_pkg::FN_JALR: begin
                        // link value is pc + 8
                        if (rt_zero && sa_zero) begin
                            br_kind    = decode_pkg::BR_JUMP_REG;
                            gr_we      = 1'b1;
                            src1_is_pc = 1'b1;
                            src2_sel   = decode_pkg::SRC2_8;
                        end
                    end
                    default: ;
                endcase
            end
            decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI, decode_pkg::OP_SLTIU: begin
                gr_we    = 1'b1;
                dest     = rt;
                src2_sel = decode_pkg::SRC2_SIMM;
                alu_op   = (op == decode_pkg::OP_SLTI)  ? decode_pkg::ALU_SLT  :
                           (op == decode_pkg::OP_SLTIU) ? decode_pkg::ALU_SLTU :
                                                          decode_pkg::ALU_ADD;
            end
            decode_pkg::OP_ANDI, decode_pkg::OP_ORI, decode_pkg::OP_XORI: begin
                gr_we    = 1'b1;
                dest     = rt;
                src2_sel = decode_pkg::SRC2_UIMM;
                alu_op   = (op == decode_pkg::OP_ANDI) ? decode_pkg::ALU_AND :
                           (op == decode_pkg::OP_ORI)  ? decode_pkg::ALU_OR  :
                                                         decode_pkg::ALU_XOR;
            end
            decode_pkg::OP_LUI: begin
                gr_we    = rs_zero;
                dest     = rt;
                src2_sel = decode_pkg::SRC2_SIMM;
                alu_op   = decode_pkg::ALU_LUI;
            end
            decode_pkg::OP_LW: begin
                gr_we    = 1'b1;
                mem_re   = 1'b1;
                dest     = rt;
                src2_sel = decode_pkg::SRC2_SIMM;
            end
            decode_pkg::OP_SW: begin
                mem_we   = 1'b1;
                src2_sel = decode_pkg::SRC2_SIMM;
            end
            decode_pkg::OP_J:   br_kind = decode_pkg::BR_JUMP;
            decode_pkg::OP_JAL: begin
                br_kind    = decode_pkg::BR_JUMP;
                gr_we      = 1'b1;
                dest       = `REG_AW'(`LINK_REG);
                src1_is_pc = 1'b1;
                src2_sel   = decode_pkg::SRC2_8;
            end
            decode_pkg::OP_BEQ: br_kind = decode_pkg::BR_BEQ;
            decode_pkg::OP_BNE: br_kind = decode_pkg::BR_BNE;
            decode_pkg::OP_BLEZ: begin
                if (rt_zero) br_kind = decode_pkg::BR_BLEZ;
            end
            decode_pkg::OP_BGTZ: begin
                if (rt_zero) br_kind = decode_pkg::BR_BGTZ;
            end
            decode_pkg::OP_REGIMM: begin
                // rt selects bltz (0) or bgez (1)
                if (rt == `REG_AW'(0)) br_kind = decode_pkg::BR_BLTZ;
                if (rt == `REG_AW'(1)) br_kind = decode_pkg::BR_BGEZ;
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/regfile.sv
`include "cpu_settings.svh"

module regfile (
    input  logic                clk,
    input  logic [`REG_AW-1:0]  raddr1,
    output logic [`DATA_W-1:0]  rdata1,
    input  logic [`REG_AW-1:0]  raddr2,
    output logic [`DATA_W-1:0]  rdata2,
    input  logic                we,
    input  logic [`REG_AW-1:0]  waddr,
    input  logic [`DATA_W-1:0]  wdata
);
    logic [`DATA_W-1:0] rf [`REG_NUM];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // $0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- rtl/operand_forward.sv
`include "cpu_settings.svh"

module operand_forward (
    input  logic [`REG_AW-1:0]  rs,
    input  logic [`REG_AW-1:0]  rt,
    input  logic [`DATA_W-1:0]  rf_rdata1,
    input  logic [`DATA_W-1:0]  rf_rdata2,
    input  logic                es_fwd_valid,
    input  logic [`REG_AW-1:0]  es_fwd_dest,
    input  logic [`DATA_W-1:0]  es_fwd_data,
    input  logic                es_load_pending,
    input  logic                ms_fwd_valid,
    input  logic [`REG_AW-1:0]  ms_fwd_dest,
    input  logic [`DATA_W-1:0]  ms_fwd_data,
    input  logic                rf_we,
    input  logic [`REG_AW-1:0]  rf_waddr,
    input  logic [`DATA_W-1:0]  rf_wdata,
    output logic [`DATA_W-1:0]  rs_value,
    output logic [`DATA_W-1:0]  rt_value,
    output logic                load_use_stall
);
    // youngest producer first
    function automatic logic [`DATA_W-1:0] pick(
        input logic [`REG_AW-1:0] src,
        input logic [`DATA_W-1:0] rf_rdata
    );
        logic [`DATA_W-1:0] value;
        value = rf_rdata;
        if (src != '0) begin
            if (es_fwd_valid && es_fwd_dest == src) value = es_fwd_data;
            else if (ms_fwd_valid && ms_fwd_dest == src) value = ms_fwd_data;
            else if (rf_we && rf_waddr == src) value = rf_wdata;
        end
        return value;
    endfunction

    always_comb begin
        rs_value = pick(rs, rf_rdata1);
        rt_value = pick(rt, rf_rdata2);
    end

    // load result not ready until memory stage
    assign load_use_stall = es_load_pending && es_fwd_dest != '0 &&
                            (es_fwd_dest == rs || es_fwd_dest == rt);

endmodule

//--- rtl/branch_unit.sv
`include "cpu_settings.svh"

module branch_unit (
    input  decode_pkg::br_kind_e  br_kind,
    input  logic [`DATA_W-1:0]    rs_value,
    input  logic [`DATA_W-1:0]    rt_value,
    input  logic [`DATA_W-1:0]    pc,
    input  logic [`IMM_W-1:0]     imm,
    input  logic [`JIDX_W-1:0]    jidx,
    output logic                  taken,
    output logic [`DATA_W-1:0]    target
);
    logic [`DATA_W-1:0] seq_pc;
    logic [`DATA_W-1:0] br_offset;
    logic               rs_eq_rt;
    logic               rs_neg;
    logic               rs_zero;

    // delay slot pc
    assign seq_pc    = pc + `DATA_W'(4);
    assign br_offset = {{(`DATA_W-`IMM_W-2){imm[`IMM_W-1]}}, imm, 2'b00};

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[`DATA_W-1];
    assign rs_zero  = (rs_value == '0);

    always_comb begin
        case (br_kind)
            decode_pkg::BR_BEQ:      taken = rs_eq_rt;
            decode_pkg::BR_BNE:      taken = !rs_eq_rt;
            decode_pkg::BR_BGEZ:     taken = !rs_neg;
            decode_pkg::BR_BGTZ:     taken = !rs_neg && !rs_zero;
            decode_pkg::BR_BLEZ:     taken = rs_neg || rs_zero;
            decode_pkg::BR_BLTZ:     taken = rs_neg;
            decode_pkg::BR_JUMP:     taken = 1'b1;
            decode_pkg::BR_JUMP_REG: taken = 1'b1;
            default:                 taken = 1'b0;
        endcase
    end

    always_comb begin
        case (br_kind)
            decode_pkg::BR_JUMP:     target = {seq_pc[`DATA_W-1 -: 4], jidx, 2'b00};
            decode_pkg::BR_JUMP_REG: target = rs_value;
            default:                 target = seq_pc + br_offset;
        endcase
    end

endmodule

//--- rtl/id_stage.sv
`include "cpu_settings.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fs_to_ds_valid,
    input  logic [`DATA_W-1:0]     fs_inst,
    input  logic [`DATA_W-1:0]     fs_pc,
    output logic                   ds_allowin,
    input  logic                   es_allowin,
    input  logic                   es_fwd_valid,
    input  logic [`REG_AW-1:0]     es_fwd_dest,
    input  logic [`DATA_W-1:0]     es_fwd_data,
    input  logic                   es_load_pending,
    input  logic                   ms_fwd_valid,
    input  logic [`REG_AW-1:0]     ms_fwd_dest,
    input  logic [`DATA_W-1:0]     ms_fwd_data,
    input  logic                   rf_we,
    input  logic [`REG_AW-1:0]     rf_waddr,
    input  logic [`DATA_W-1:0]     rf_wdata,
    output logic                   ds_to_es_valid,
    output logic [`DATA_W-1:0]     es_pc,
    output decode_pkg::alu_op_e    es_alu_op,
    output logic                   es_src1_is_sa,
    output logic                   es_src1_is_pc,
    output decode_pkg::src2_sel_e  es_src2_sel,
    output logic                   es_gr_we,
    output logic                   es_mem_we,
    output logic                   es_mem_re,
    output logic [`REG_AW-1:0]     es_dest,
    output logic [`IMM_W-1:0]      es_imm,
    output logic [`DATA_W-1:0]     es_rs_value,
    output logic [`DATA_W-1:0]     es_rt_value,
    output logic                   br_taken,
    output logic [`DATA_W-1:0]     br_target,
    output logic                   br_stall
);
    logic                  ds_valid;
    logic [`DATA_W-1:0]    ds_inst;
    logic [`DATA_W-1:0]    ds_pc;
    logic                  ds_ready_go;
    logic [`REG_AW-1:0]    rs;
    logic [`REG_AW-1:0]    rt;
    logic [`DATA_W-1:0]    rf_rdata1;
    logic [`DATA_W-1:0]    rf_rdata2;
    logic [`JIDX_W-1:0]    jidx;
    decode_pkg::br_kind_e  br_kind;
    logic                  load_use_stall;
    logic                  br_cond;

    assign ds_ready_go    = !load_use_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    assign es_pc = ds_pc;

    inst_decoder u_decoder (
        .inst       (ds_inst),
        .rs         (rs),
        .rt         (rt),
        .alu_op     (es_alu_op),
        .src1_is_sa (es_src1_is_sa),
        .src1_is_pc (es_src1_is_pc),
        .src2_sel   (es_src2_sel),
        .gr_we      (es_gr_we),
        .mem_we     (es_mem_we),
        .mem_re     (es_mem_re),
        .dest       (es_dest),
        .imm        (es_imm),
        .jidx       (jidx),
        .br_kind    (br_kind)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .rdata1 (rf_rdata1),
        .raddr2 (rt),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    operand_forward u_forward (
        .rs              (rs),
        .rt              (rt),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .es_fwd_valid    (es_fwd_valid),
        .es_fwd_dest     (es_fwd_dest),
        .es_fwd_data     (es_fwd_data),
        .es_load_pending (es_load_pending),
        .ms_fwd_valid    (ms_fwd_valid),
        .ms_fwd_dest     (ms_fwd_dest),
        .ms_fwd_data     (ms_fwd_data),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .rs_value        (es_rs_value),
        .rt_value        (es_rt_value),
        .load_use_stall  (load_use_stall)
    );

    branch_unit u_branch (
        .br_kind  (br_kind),
        .rs_value (es_rs_value),
        .rt_value (es_rt_value),
        .pc       (ds_pc),
        .imm      (es_imm),
        .jidx     (jidx),
        .taken    (br_cond),
        .target   (br_target)
    );

    // fetch ignores the target while br_stall is high
    assign br_taken = ds_valid && br_cond;
    assign br_stall = ds_valid && load_use_stall && (br_kind != decode_pkg::BR_NONE);

endmodule

//--- tb/id_stage_assert.sv
module id_stage_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  fs_to_ds_valid,
    input logic                  ds_allowin,
    input logic [31:0]           ds_inst,
    input logic                  es_load_pending,
    input logic [4:0]            es_fwd_dest,
    input logic                  ds_to_es_valid,
    input logic                  es_allowin,
    input logic                  br_taken,
    input decode_pkg::alu_op_e   es_alu_op,
    input logic [31:0]           es_pc,
    input logic [4:0]            es_dest,
    input logic [31:0]           es_rs_value,
    input logic [31:0]           es_rt_value
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic full_q;
    logic hazard;

    // occupancy as seen from the two handshakes
    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
        end else if (fs_to_ds_valid && ds_allowin) begin
            full_q <= 1'b1;
        end else if (ds_to_es_valid && es_allowin) begin
            full_q <= 1'b0;
        end
    end

    // load in execute feeds rs or rt
    assign hazard = es_load_pending && es_fwd_dest != 5'd0 &&
                    (es_fwd_dest == ds_inst[25:21] || es_fwd_dest == ds_inst[20:16]);

    no_issue_in_stall: assert property (@(posedge clk) disable iff (reset)
        hazard |-> (!ds_to_es_valid && (!full_q || !ds_allowin)))
        else begin
            fail_count++;
            $error("stage issued or accepted during a load-use stall");
        end

    taken_needs_full: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> full_q)
        else begin
            fail_count++;
            $error("br_taken high while the stage is empty");
        end

    // held outputs under back-pressure
    hold_when_blocked: assert property (@(posedge clk) disable iff (reset)
        (ds_to_es_valid && !es_allowin) |=>
            ($stable(es_alu_op) && $stable(es_pc) && $stable(es_dest) &&
             $stable(es_rs_value) && $stable(es_rt_value)))
        else begin
            fail_count++;
            $error("outputs changed while execute held the stage");
        end

endmodule

bind id_stage id_stage_assert u_id_stage_assert (
    .clk             (clk),
    .reset           (reset),
    .fs_to_ds_valid  (fs_to_ds_valid),
    .ds_allowin      (ds_allowin),
    .ds_inst         (ds_inst),
    .es_load_pending (es_load_pending),
    .es_fwd_dest     (es_fwd_dest),
    .ds_to_es_valid  (ds_to_es_valid),
    .es_allowin      (es_allowin),
    .br_taken        (br_taken),
    .es_alu_op       (es_alu_op),
    .es_pc           (es_pc),
    .es_dest         (es_dest),
    .es_rs_value     (es_rs_value),
    .es_rt_value     (es_rt_value)
);

//--- tb/id_stage_tb.sv
`include "cpu_settings.svh"

module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int NUM_F   = 22;
    localparam int PERIOD  = 40;

    logic                   clk;
    logic                   reset;
    logic                   fs_to_ds_valid;
    logic [`DATA_W-1:0]     fs_inst;
    logic [`DATA_W-1:0]     fs_pc;
    logic                   ds_allowin;
    logic                   es_allowin;
    logic                   es_fwd_valid;
    logic [`REG_AW-1:0]     es_fwd_dest;
    logic [`DATA_W-1:0]     es_fwd_data;
    logic                   es_load_pending;
    logic                   ms_fwd_valid;
    logic [`REG_AW-1:0]     ms_fwd_dest;
    logic [`DATA_W-1:0]     ms_fwd_data;
    logic                   rf_we;
    logic [`REG_AW-1:0]     rf_waddr;
    logic [`DATA_W-1:0]     rf_wdata;
    logic                   ds_to_es_valid;
    logic [`DATA_W-1:0]     es_pc;
    decode_pkg::alu_op_e    es_alu_op;
    logic                   es_src1_is_sa;
    logic                   es_src1_is_pc;
    decode_pkg::src2_sel_e  es_src2_sel;
    logic                   es_gr_we;
    logic                   es_mem_we;
    logic                   es_mem_re;
    logic [`REG_AW-1:0]     es_dest;
    logic [`IMM_W-1:0]      es_imm;
    logic [`DATA_W-1:0]     es_rs_value;
    logic [`DATA_W-1:0]     es_rt_value;
    logic                   br_taken;
    logic [`DATA_W-1:0]     br_target;
    logic                   br_stall;

    logic [31:0] vec [0:MAX_VEC-1][0:NUM_F-1];
    int          num_vec;
    int          checks;
    int          errors;
    bit          loaded;

    id_stage uut (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    // sll, srl and sra take the shift amount field, rs must be zero
    function automatic logic uses_shift_amount(input logic [31:0] inst);
        logic [5:0] op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        return op == 6'h00 && inst[25:21] == 5'd0 &&
               (fn == 6'h00 || fn == 6'h02 || fn == 6'h03);
    endfunction

    // jal, and jalr with rt and sa zero
    function automatic logic links_pc(input logic [31:0] inst);
        logic [5:0] op;
        logic [5:0] fn;
        op = inst[31:26];
        fn = inst[5:0];
        return op == 6'h03 ||
               (op == 6'h00 && fn == 6'h09 && inst[20:16] == 5'd0 &&
                inst[10:6] == 5'd0);
    endfunction

    // columns: inst pc es_v es_d es_data es_lp ms_v ms_d ms_data rf_we rf_wa rf_wd
    // es_allowin, then alu dest src2 we rs rt taken target stall
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen("tb/id_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open stimulus file tb/id_stimulus.txt");
        end else begin
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[num_vec][0], vec[num_vec][1], vec[num_vec][2],
                        vec[num_vec][3], vec[num_vec][4], vec[num_vec][5],
                        vec[num_vec][6], vec[num_vec][7], vec[num_vec][8],
                        vec[num_vec][9], vec[num_vec][10], vec[num_vec][11],
                        vec[num_vec][12], vec[num_vec][13], vec[num_vec][14],
                        vec[num_vec][15], vec[num_vec][16], vec[num_vec][17],
                        vec[num_vec][18], vec[num_vec][19], vec[num_vec][20],
                        vec[num_vec][21]);
                    if (n == NUM_F) begin
                        num_vec++;
                    end else begin
                        errors++;
                        $display("malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic clear_side_inputs();
        es_fwd_valid    = 1'b0;
        es_fwd_dest     = '0;
        es_fwd_data     = '0;
        es_load_pending = 1'b0;
        ms_fwd_valid    = 1'b0;
        ms_fwd_dest     = '0;
        ms_fwd_data     = '0;
        rf_we           = 1'b0;
        rf_waddr        = '0;
        rf_wdata        = '0;
        es_allowin      = 1'b1;
    endtask

    task automatic run_vector(input int i);
        logic [31:0] exp_we;
        exp_we = vec[i][16];
        @(negedge clk);
        check_value("ds_allowin", ds_allowin, 1);
        fs_inst         = vec[i][0];
        fs_pc           = vec[i][1];
        fs_to_ds_valid  = 1'b1;
        es_fwd_valid    = vec[i][2][0];
        es_fwd_dest     = vec[i][3][`REG_AW-1:0];
        es_fwd_data     = vec[i][4];
        es_load_pending = vec[i][5][0];
        ms_fwd_valid    = vec[i][6][0];
        ms_fwd_dest     = vec[i][7][`REG_AW-1:0];
        ms_fwd_data     = vec[i][8];
        rf_we           = vec[i][9][0];
        rf_waddr        = vec[i][10][`REG_AW-1:0];
        rf_wdata        = vec[i][11];
        es_allowin      = vec[i][12][0];
        @(negedge clk);
        fs_to_ds_valid = 1'b0;
        check_value("es_pc", es_pc, vec[i][1]);
        check_value("es_alu_op", es_alu_op, vec[i][13]);
        check_value("es_dest", es_dest, vec[i][14]);
        check_value("es_src2_sel", es_src2_sel, vec[i][15]);
        check_value("es_src1_is_sa", es_src1_is_sa, uses_shift_amount(vec[i][0]));
        check_value("es_src1_is_pc", es_src1_is_pc, links_pc(vec[i][0]));
        check_value("es_imm", es_imm, vec[i][0][15:0]);
        check_value("es_gr_we", es_gr_we, exp_we[2]);
        check_value("es_mem_we", es_mem_we, exp_we[1]);
        check_value("es_mem_re", es_mem_re, exp_we[0]);
        check_value("es_rs_value", es_rs_value, vec[i][17]);
        check_value("es_rt_value", es_rt_value, vec[i][18]);
        check_value("br_taken", br_taken, vec[i][19]);
        check_value("br_target", br_target, vec[i][20]);
        if (vec[i][21][0]) begin
            check_value("ds_to_es_valid", ds_to_es_valid, 0);
            check_value("ds_allowin", ds_allowin, 0);
            check_value("br_stall", br_stall, 0);
            // held over a rising edge while the load is pending
            @(negedge clk);
            check_value("ds_to_es_valid", ds_to_es_valid, 0);
            check_value("ds_allowin", ds_allowin, 0);
            check_value("es_pc", es_pc, vec[i][1]);
            // load data arrives, hazard clears
            es_load_pending = 1'b0;
            #1;
        end
        check_value("ds_to_es_valid", ds_to_es_valid, 1);
        if (!es_allowin) begin
            @(negedge clk);
            check_value("ds_to_es_valid", ds_to_es_valid, 1);
            check_value("ds_allowin", ds_allowin, 0);
            check_value("es_dest", es_dest, vec[i][14]);
            check_value("es_rs_value", es_rs_value, vec[i][17]);
            es_allowin = 1'b1;
        end
        while (!(ds_to_es_valid && es_allowin)) begin
            @(negedge clk);
        end
        @(negedge clk);
        clear_side_inputs();
        // one transfer only, stage is empty again
        check_value("ds_to_es_valid", ds_to_es_valid, 0);
        check_value("ds_allowin", ds_allowin, 1);
    endtask

    initial begin : watchdog
        wait (loaded);
        #((num_vec * 6 + 20) * PERIOD);
        $display("timeout: the run did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst        = '0;
        fs_pc          = '0;
        clear_side_inputs();
        load_vectors();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("ds_to_es_valid", ds_to_es_valid, 0);
        check_value("br_taken", br_taken, 0);
        check_value("br_stall", br_stall, 0);
        check_value("ds_allowin", ds_allowin, 1);
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        $display("vectors: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 num_vec, checks, errors, uut.u_id_stage_assert.fail_count);
        if (errors == 0 && uut.u_id_stage_assert.fail_count == 0 && num_vec > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- tb/id_stimulus.txt
# inst pc es_v es_d es_data es_lp ms_v ms_d ms_data rf_we rf_wa rf_wd es_allowin
# exp: alu dest src2 we(gr,mw,mr) rs_value rt_value taken target stall
00201821 00400000 0 0 00000000 0 0 0 00000000 1 1 11111111 1 0 03 0 4 11111111 00000000 0 00406088 0
00222023 00400004 0 0 00000000 0 0 0 00000000 1 2 22222222 1 1 04 0 4 11111111 22222222 0 00408094 0
00222824 00400008 1 1 aaaa0001 0 1 1 bbbb0001 1 1 cccc0001 1 4 05 0 4 aaaa0001 22222222 0 0040a09c 0
00223025 0040000c 0 1 dead0000 0 1 2 12345678 1 2 87654321 1 6 06 0 4 cccc0001 12345678 0 0040c0a4 0
00003826 00400010 1 0 deadbeef 0 0 0 00000000 1 0 ffffffff 1 7 07 0 4 00000000 00000000 0 0040e0ac 0
2428fffc 00400014 0 0 00000000 0 1 8 00000008 0 0 00000000 1 0 08 1 4 cccc0001 00000008 0 00400008 0
3c091234 00400018 0 0 00000000 0 0 0 00000000 1 9 99999999 1 b 09 1 4 00000000 99999999 0 004048ec 0
342a00ff 0040001c 0 0 00000000 0 0 0 00000000 1 a 0000000a 1 6 0a 2 4 cccc0001 0000000a 0 0040041c 0
8c2b0008 00400020 0 0 00000000 0 0 0 00000000 1 b 0000000b 1 0 0b 1 5 cccc0001 0000000b 0 00400044 0
ac220004 00400024 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 1 2 cccc0001 87654321 0 00400038 0
00026100 00400028 0 0 00000000 0 0 0 00000000 0 0 00000000 1 8 0c 0 4 00000000 87654321 0 0041842c 0
fc000000 0040002c 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 00000000 00000000 0 00400030 0
00226821 00400030 1 2 5555aaaa 1 0 0 00000000 0 0 00000000 1 0 0d 0 4 cccc0001 5555aaaa 0 0041a0b8 1
10210004 00400034 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 cccc0001 cccc0001 1 00400048 0
1422fffe 00400038 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 1f 0 0 cccc0001 87654321 1 00400034 0
04210010 0040003c 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 cccc0001 cccc0001 0 00400080 0
04200010 00400040 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 cccc0001 00000000 1 00400084 0
1d400008 00400044 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 0000000a 00000000 1 00400068 0
18000008 00400048 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 00000000 00000000 1 0040006c 0
08010040 0040004c 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 00000000 cccc0001 1 00040100 0
0c010040 90000000 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 1f 3 4 00000000 cccc0001 1 90040100 0
01400008 00400050 0 0 00000000 0 0 0 00000000 0 0 00000000 1 0 00 0 0 0000000a 00000000 1 0000000a 0
00227021 00400054 0 0 00000000 0 0 0 00000000 0 0 00000000 0 0 0e 0 4 cccc0001 87654321 0 0041c0dc 0

//--- list.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/regfile.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/id_stage.sv
tb/id_stage_assert.sv
tb/id_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= id_stage_tb
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
